// File: hw/core_mem_pkg.sv
// Vector typedefs and arbiter state enum for the core memory side
`include "core_mem_consts.svh"

package core_mem_pkg;

	// Strand number, 2 bits for 4 strands
	typedef logic [$clog2(`STRANDS)-1:0] strand_idx_t;

	// One bit per strand, used for wakeups
	typedef logic [`STRANDS-1:0] strand_mask_t;

	typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;	// Line granular address

	// Byte b of a line sits at bits [b*8 +: 8]
	typedef logic [`LINE_BYTES*8-1:0] line_data_t;
	typedef logic [`LINE_BYTES-1:0] byte_mask_t;	// Bit b enables byte b

	typedef logic [`UNIT_BITS-1:0] unit_t;	// Requester ID
	typedef logic [`OP_BITS-1:0] l2_op_t;	// Load or store

	// Arbiter grant FSM
	typedef enum logic
	{
		ARB_IDLE,	// Free to pick a new requester
		ARB_HOLD	// Grant parked until L2 takes it
	} arb_state_t;

endpackage

// File: hw/core_mem_top.sv
// Core memory side top level: store buffer, L2 request arbiter and response router
`include "core_mem_consts.svh"

module core_mem_top
	#(parameter logic [3:0] CORE_ID = 4'd0)
	(input                              clk,
	input                               reset,
	input                               store_valid_i,
	input core_mem_pkg::strand_idx_t    store_strand_i,
	input core_mem_pkg::line_addr_t     store_addr_i,
	input core_mem_pkg::line_data_t     store_data_i,
	input core_mem_pkg::byte_mask_t     store_mask_i,
	output logic                        rollback_o,
	input                               load_valid_i,
	input core_mem_pkg::strand_idx_t    load_strand_i,
	input core_mem_pkg::line_addr_t     load_addr_i,
	input core_mem_pkg::line_data_t     cache_line_i,
	output core_mem_pkg::line_data_t    load_data_o,
	input                               dload_req_valid_i,
	input core_mem_pkg::strand_idx_t    dload_req_strand_i,
	input core_mem_pkg::line_addr_t     dload_req_addr_i,
	output logic                        l2req_dload_ready_o,
	output logic                        l2req_valid_o,
	input                               l2req_ready_i,
	output core_mem_pkg::strand_idx_t   l2req_strand_o,
	output core_mem_pkg::unit_t         l2req_unit_o,
	output core_mem_pkg::l2_op_t        l2req_op_o,
	output core_mem_pkg::line_addr_t    l2req_addr_o,
	output core_mem_pkg::line_data_t    l2req_data_o,
	output core_mem_pkg::byte_mask_t    l2req_mask_o,
	input                               l2rsp_valid_i,
	input [3:0]                         l2rsp_core_i,
	input core_mem_pkg::unit_t          l2rsp_unit_i,
	input core_mem_pkg::strand_idx_t    l2rsp_strand_i,
	input core_mem_pkg::line_addr_t     l2rsp_addr_i,
	output core_mem_pkg::strand_mask_t  resume_strands_o);

	l2_req_if dload_req();	// Load misses from outside
	l2_req_if stbuf_req();	// Store buffer issue
	l2_rsp_if stbuf_rsp();	// Store completions

	// Load miss is a line fill, nothing to write
	assign dload_req.valid = dload_req_valid_i;
	assign dload_req.strand = dload_req_strand_i;
	assign dload_req.unit = core_mem_pkg::unit_t'(`UNIT_DLOAD);
	assign dload_req.op = core_mem_pkg::l2_op_t'(`OP_LOAD);
	assign dload_req.addr = dload_req_addr_i;
	assign dload_req.data = '0;
	assign dload_req.mask = '0;
	assign l2req_dload_ready_o = dload_req.ready;

	store_buffer i_store_buffer
	(
		.clk           (clk),
		.reset         (reset),
		.store_valid_i (store_valid_i),
		.store_strand_i(store_strand_i),
		.store_addr_i  (store_addr_i),
		.store_data_i  (store_data_i),
		.store_mask_i  (store_mask_i),
		.rollback_o    (rollback_o),
		.load_valid_i  (load_valid_i),
		.load_strand_i (load_strand_i),
		.load_addr_i   (load_addr_i),
		.cache_line_i  (cache_line_i),
		.load_data_o   (load_data_o),
		.req           (stbuf_req.requester),
		.rsp           (stbuf_rsp.consumer)
	);

	l2_arbiter i_l2_arbiter
	(
		.clk           (clk),
		.reset         (reset),
		.dload         (dload_req.arbiter),
		.stbuf         (stbuf_req.arbiter),
		.l2req_valid_o (l2req_valid_o),
		.l2req_ready_i (l2req_ready_i),
		.l2req_strand_o(l2req_strand_o),
		.l2req_unit_o  (l2req_unit_o),
		.l2req_op_o    (l2req_op_o),
		.l2req_addr_o  (l2req_addr_o),
		.l2req_data_o  (l2req_data_o),
		.l2req_mask_o  (l2req_mask_o)
	);

	l2_response_router #(.CORE_ID(CORE_ID)) i_l2_response_router
	(
		.clk             (clk),
		.reset           (reset),
		.l2rsp_valid_i   (l2rsp_valid_i),
		.l2rsp_core_i    (l2rsp_core_i),
		.l2rsp_unit_i    (l2rsp_unit_i),
		.l2rsp_strand_i  (l2rsp_strand_i),
		.l2rsp_addr_i    (l2rsp_addr_i),
		.rsp             (stbuf_rsp.producer),
		.resume_strands_o(resume_strands_o)
	);

endmodule

// File: hw/l2_arbiter.sv
// Round-robin L2 request arbiter between load miss and store buffer, grant held until accepted
module l2_arbiter
	(input                            clk,
	input                             reset,
	l2_req_if.arbiter                 dload,
	l2_req_if.arbiter                 stbuf,
	output logic                      l2req_valid_o,
	input                             l2req_ready_i,
	output core_mem_pkg::strand_idx_t l2req_strand_o,
	output core_mem_pkg::unit_t       l2req_unit_o,
	output core_mem_pkg::l2_op_t      l2req_op_o,
	output core_mem_pkg::line_addr_t  l2req_addr_o,
	output core_mem_pkg::line_data_t  l2req_data_o,
	output core_mem_pkg::byte_mask_t  l2req_mask_o);

	core_mem_pkg::arb_state_t state;
	logic last_stbuf;	// Store buffer had the last transfer
	logic held_stbuf;	// Grant parked in ARB_HOLD
	logic sel_stbuf;	// Current grant, 0 means load miss

	always_comb
	begin
		if (state == core_mem_pkg::ARB_HOLD)
			sel_stbuf = held_stbuf;
		else if (dload.valid && stbuf.valid)
			sel_stbuf = !last_stbuf;	// Both want it, other side's turn
		else
			sel_stbuf = stbuf.valid;
	end

	assign l2req_valid_o = sel_stbuf ? stbuf.valid : dload.valid;
	assign l2req_strand_o = sel_stbuf ? stbuf.strand : dload.strand;
	assign l2req_unit_o = sel_stbuf ? stbuf.unit : dload.unit;
	assign l2req_op_o = sel_stbuf ? stbuf.op : dload.op;
	assign l2req_addr_o = sel_stbuf ? stbuf.addr : dload.addr;
	assign l2req_data_o = sel_stbuf ? stbuf.data : dload.data;
	assign l2req_mask_o = sel_stbuf ? stbuf.mask : dload.mask;

	// Ready goes back to the granted side only
	assign dload.ready = l2req_ready_i && !sel_stbuf;
	assign stbuf.ready = l2req_ready_i && sel_stbuf;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= core_mem_pkg::ARB_IDLE;
			last_stbuf <= 1'b0;
			held_stbuf <= 1'b0;
		end
		else
		begin
			case (state)
				core_mem_pkg::ARB_IDLE:
				begin
					if (l2req_valid_o && l2req_ready_i)
						last_stbuf <= sel_stbuf;	// Taken at once, no hold
					else if (l2req_valid_o)
					begin
						state <= core_mem_pkg::ARB_HOLD;
						held_stbuf <= sel_stbuf;
					end
				end

				core_mem_pkg::ARB_HOLD:
				begin
					if (l2req_ready_i)
					begin
						state <= core_mem_pkg::ARB_IDLE;
						last_stbuf <= held_stbuf;	// Flip priority
					end
				end
			endcase
		end
	end

endmodule

// File: hw/l2_if.sv
// L2 request interface and routed L2 response interface, with modports

// One requester's path to the L2 request arbiter
interface l2_req_if;
	logic                      valid;	// Request pending
	logic                      ready;	// Arbiter and L2 take it this cycle
	core_mem_pkg::strand_idx_t strand;
	core_mem_pkg::unit_t       unit;
	core_mem_pkg::l2_op_t      op;
	core_mem_pkg::line_addr_t  addr;
	core_mem_pkg::line_data_t  data;	// Store payload
	core_mem_pkg::byte_mask_t  mask;	// Store byte enables

	// Fields held stable from valid until valid && ready
	modport requester
	(
		output valid,
		output strand,
		output unit,
		output op,
		output addr,
		output data,
		output mask,
		input  ready
	);

	modport arbiter
	(
		input  valid,
		input  strand,
		input  unit,
		input  op,
		input  addr,
		input  data,
		input  mask,
		output ready
	);
endinterface

// Responses already filtered to this core and the store buffer unit
interface l2_rsp_if;
	logic                      valid;
	core_mem_pkg::strand_idx_t strand;	// Strand whose store completed
	core_mem_pkg::line_addr_t  addr;	// Line the store went to

	modport producer(output valid, output strand, output addr);
	modport consumer(input valid, input strand, input addr);
endinterface

// File: hw/l2_response_router.sv
// L2 response filter by core and unit, registered strand wakeup, store completion path
`include "core_mem_consts.svh"

module l2_response_router
	#(parameter logic [3:0] CORE_ID = 4'd0)
	(input                             clk,
	input                              reset,
	input                              l2rsp_valid_i,
	input [3:0]                        l2rsp_core_i,
	input core_mem_pkg::unit_t         l2rsp_unit_i,
	input core_mem_pkg::strand_idx_t   l2rsp_strand_i,
	input core_mem_pkg::line_addr_t    l2rsp_addr_i,
	l2_rsp_if.producer                 rsp,
	output core_mem_pkg::strand_mask_t resume_strands_o);

	logic for_me;	// Response addressed to this core
	logic is_dload;
	logic is_stbuf;

	assign for_me = l2rsp_valid_i && l2rsp_core_i == CORE_ID;
	assign is_dload = l2rsp_unit_i == core_mem_pkg::unit_t'(`UNIT_DLOAD);
	assign is_stbuf = l2rsp_unit_i == core_mem_pkg::unit_t'(`UNIT_STBUF);

	// Unregistered, so the entry frees on the same edge as the wakeup
	assign rsp.valid = for_me && is_stbuf;
	assign rsp.strand = l2rsp_strand_i;
	assign rsp.addr = l2rsp_addr_i;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resume_strands_o <= '0;
		else if (for_me && (is_dload || is_stbuf))
			resume_strands_o <= core_mem_pkg::strand_mask_t'(1) << l2rsp_strand_i;	// One-hot
		else
			resume_strands_o <= '0;	// Pulse lasts one cycle
	end

endmodule

// File: hw/store_buffer.sv
// Per-strand store entries, rollback, load forwarding merge and L2 store issue
`include "core_mem_consts.svh"

module store_buffer
	(input                            clk,
	input                             reset,
	input                             store_valid_i,
	input core_mem_pkg::strand_idx_t  store_strand_i,
	input core_mem_pkg::line_addr_t   store_addr_i,
	input core_mem_pkg::line_data_t   store_data_i,
	input core_mem_pkg::byte_mask_t   store_mask_i,
	output logic                      rollback_o,
	input                             load_valid_i,
	input core_mem_pkg::strand_idx_t  load_strand_i,
	input core_mem_pkg::line_addr_t   load_addr_i,
	input core_mem_pkg::line_data_t   cache_line_i,
	output core_mem_pkg::line_data_t  load_data_o,
	l2_req_if.requester               req,
	l2_rsp_if.consumer                rsp);

	core_mem_pkg::strand_mask_t entry_valid;	// Store held for strand
	core_mem_pkg::strand_mask_t entry_issued;	// Already taken by L2
	core_mem_pkg::line_addr_t   entry_addr[`STRANDS];
	core_mem_pkg::line_data_t   entry_data[`STRANDS];
	core_mem_pkg::byte_mask_t   entry_mask[`STRANDS];

	core_mem_pkg::strand_mask_t pending;	// Waiting to go out to L2
	core_mem_pkg::strand_idx_t  pick_strand;	// Lowest pending strand
	logic                       req_locked;	// Request seen but not yet taken
	core_mem_pkg::strand_idx_t  locked_strand;
	core_mem_pkg::strand_idx_t  issue_strand;
	logic                       store_accept;
	logic                       rsp_clear;
	logic                       load_hit;
	core_mem_pkg::line_data_t   merged;

	assign pending = entry_valid & ~entry_issued;

	always_comb
	begin
		pick_strand = '0;
		for (int i = `STRANDS - 1; i >= 0; i--)	// Downward so lowest wins
		begin
			if (pending[i])
				pick_strand = core_mem_pkg::strand_idx_t'(i);
		end
	end

	// A lower strand arriving later must not swap out a request already on the bus
	assign issue_strand = req_locked ? locked_strand : pick_strand;

	assign req.valid = |pending;	// Locked strand stays pending until taken
	assign req.strand = issue_strand;
	assign req.unit = core_mem_pkg::unit_t'(`UNIT_STBUF);
	assign req.op = core_mem_pkg::l2_op_t'(`OP_STORE);
	assign req.addr = entry_addr[issue_strand];
	assign req.data = entry_data[issue_strand];
	assign req.mask = entry_mask[issue_strand];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			req_locked <= 1'b0;
			locked_strand <= '0;
		end
		else if (req.valid && req.ready)
			req_locked <= 1'b0;	// Transfer done
		else if (req.valid && !req_locked)
		begin
			req_locked <= 1'b1;	// Stalled, freeze the choice
			locked_strand <= pick_strand;
		end
	end

	assign store_accept = store_valid_i && !entry_valid[store_strand_i];

	// Completion must name the line that was sent
	assign rsp_clear = rsp.valid && entry_valid[rsp.strand] && entry_issued[rsp.strand]
		&& entry_addr[rsp.strand] == rsp.addr;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_issued <= '0;
			rollback_o <= 1'b0;
		end
		else
		begin
			rollback_o <= store_valid_i && !store_accept;	// Entry busy, strand retries
			if (req.valid && req.ready)
				entry_issued[issue_strand] <= 1'b1;
			if (rsp_clear)
				entry_valid[rsp.strand] <= 1'b0;	// Slot free from next cycle
			if (store_accept)
			begin
				entry_valid[store_strand_i] <= 1'b1;
				entry_issued[store_strand_i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_accept)
		begin
			entry_addr[store_strand_i] <= store_addr_i;
			entry_data[store_strand_i] <= store_data_i;
			entry_mask[store_strand_i] <= store_mask_i;
		end
	end

	// Only the loading strand's own store is visible to it
	assign load_hit = entry_valid[load_strand_i] && entry_addr[load_strand_i] == load_addr_i;

	always_comb
	begin
		merged = cache_line_i;
		for (int b = 0; b < `LINE_BYTES; b++)
		begin
			if (load_hit && entry_mask[load_strand_i][b])
				merged[b*8 +: 8] = entry_data[load_strand_i][b*8 +: 8];	// Pending byte wins
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_valid_i)
			load_data_o <= merged;
	end

endmodule

// File: include/core_mem_consts.svh
// Strand count, line geometry, address width, unit and op codes
`ifndef CORE_MEM_CONSTS_SVH
`define CORE_MEM_CONSTS_SVH

// Hardware threads per core
`define STRANDS 4

// Bytes in one cache line
`define LINE_BYTES 16

// Line address, byte offset already stripped
`define LINE_ADDR_BITS 28

// Requester IDs carried in the unit field
`define UNIT_DLOAD 0
`define UNIT_STBUF 1

// L2 request opcodes
`define OP_LOAD 0
`define OP_STORE 1

// Field widths
`define UNIT_BITS 2
`define OP_BITS 2

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the core memory testbench with Verilator

verilator --binary --timing --assert -f verilog.f --top-module core_mem_tb \
	-o core_mem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/core_mem_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// File: testbench/core_mem_checker.sv
// Checker: records L2 transfers against expected requests, compares rollback, load and resume
`include "core_mem_consts.svh"

module core_mem_checker
	(input                            clk,
	input                             l2req_valid_o,
	input                             l2req_ready_i,
	input                             l2req_dload_ready_o,
	input core_mem_pkg::strand_idx_t  l2req_strand_o,
	input core_mem_pkg::unit_t        l2req_unit_o,
	input core_mem_pkg::l2_op_t       l2req_op_o,
	input core_mem_pkg::line_addr_t   l2req_addr_o,
	input core_mem_pkg::line_data_t   l2req_data_o,
	input core_mem_pkg::byte_mask_t   l2req_mask_o,
	input                             rollback_o,
	input core_mem_pkg::line_data_t   load_data_o,
	input core_mem_pkg::strand_mask_t resume_strands_o);
	timeunit 1ns;
	timeprecision 100ps;

	logic [177:0] exp_reqs[$];	// {strand, unit, op, addr, data, mask}, in grant order
	string exp_names[$];
	int pass_count = 0;
	int fail_count = 0;

	function automatic int pending_requests();
		return exp_reqs.size();
	endfunction

	function automatic int failed_checks();
		return fail_count;
	endfunction

	task automatic report(input string name, input string what, input logic [178:0] exp,
		input logic [178:0] act);
		begin
			if (exp === act)
			begin
				pass_count++;
				$display("Pass %s %s", name, what);
			end
			else
			begin
				fail_count++;
				$display("Fail %s %s expected %h actual %h", name, what, exp, act);
			end
		end
	endtask

	task automatic expect_request(input string name, input logic [1:0] strand, unit, op,
		input logic [27:0] addr, input logic [127:0] data, input logic [15:0] mask);
		begin
			exp_reqs.push_back({strand, unit, op, addr, data, mask});
			exp_names.push_back(name);
		end
	endtask

	task automatic match_rollback(input string name, input logic exp);
		report(name, "rollback", 179'(exp), 179'(rollback_o));
	endtask

	task automatic compare_load_data(input string name, input logic [127:0] exp);
		report(name, "load data", 179'(exp), 179'(load_data_o));
	endtask

	task automatic verify_resume(input string name, input logic [3:0] exp);
		report(name, "resume", 179'(exp), 179'(resume_strands_o));
	endtask

	task automatic print_summary();
		$display("Summary: %0d checks passed, %0d failed, %0d requests missing",
			pass_count, fail_count, exp_reqs.size());
	endtask

	// Mid cycle sample, the transfer itself lands on the next rising edge
	initial
	begin
		logic [177:0] act;
		logic [177:0] exp_req;
		logic exp_ready;
		forever
		begin
			@(negedge clk);
			if (l2req_valid_o && l2req_ready_i)
			begin
				act = {l2req_strand_o, l2req_unit_o, l2req_op_o, l2req_addr_o,
					l2req_data_o, l2req_mask_o};
				if (exp_reqs.size() == 0)
				begin
					fail_count++;
					$display("Unexpected L2 request transfer with fields %h", act);
				end
				else
				begin
					exp_req = exp_reqs.pop_front();
					// Ready reaches the load miss port only when it holds the grant
					exp_ready = exp_req[175:174] == `UNIT_DLOAD;
					report(exp_names.pop_front(), "L2 request", {exp_req, exp_ready},
						{act, l2req_dload_ready_o});
				end
			end
		end
	end

endmodule

// File: testbench/core_mem_stim.txt
// Columns: test op strand addr data mask expect, op 1 store 2 load 3 dload 4 rsp 5 ready
// rsp puts core in data and unit in mask, ready puts its level in data, op 0 ends
01 1 0 0000010 00112233445566778899aabbccddeeff 00ff 0
02 1 0 0000030 ffeeddccbbaa99887766554433221100 ffff 1
03 2 0 0000010 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0 a5a5a5a5a5a5a5a58899aabbccddeeff
04 2 1 0000010 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
05 2 0 0000020 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
06 4 0 0000010 3 1 1
07 1 0 0000020 0f1e2d3c4b5a69788796a5b4c3d2e1f0 ffff 0
08 4 0 0000020 5 1 0
09 4 0 0000020 3 1 1
0a 5 0 0000000 0 0 0
0b 3 2 0000040 0 0 0
0c 1 1 0000050 deadbeefcafef00d0123456789abcdef f0f0 0
0d 5 0 0000000 1 0 0
0e 4 1 0000050 3 1 2
0f 4 2 0000040 3 0 4
10 5 0 0000000 0 0 0
11 1 3 0000060 00112233445566778899aabbccddeeff ffff 0
12 3 0 0000070 0 0 0
13 5 0 0000000 1 0 0
14 4 3 0000060 3 1 8
00 0 0 0000000 0 0 0

// File: testbench/core_mem_sva.sv
// Bound assertions: L2 request stability under back-pressure, control outputs low after reset
module core_mem_sva
	(input                            clk,
	input                             reset,
	input                             l2req_valid_o,
	input                             l2req_ready_i,
	input core_mem_pkg::strand_idx_t  l2req_strand_o,
	input core_mem_pkg::unit_t        l2req_unit_o,
	input core_mem_pkg::l2_op_t       l2req_op_o,
	input core_mem_pkg::line_addr_t   l2req_addr_o,
	input core_mem_pkg::line_data_t   l2req_data_o,
	input core_mem_pkg::byte_mask_t   l2req_mask_o,
	input                             rollback_o,
	input core_mem_pkg::strand_mask_t resume_strands_o);
	timeunit 1ns;
	timeprecision 100ps;

	// Stalled request must still be there, unchanged, one cycle on
	assert property (@(posedge clk) disable iff (reset)
		l2req_valid_o && !l2req_ready_i |=> l2req_valid_o && $stable(l2req_strand_o)
		&& $stable(l2req_unit_o) && $stable(l2req_op_o) && $stable(l2req_addr_o)
		&& $stable(l2req_data_o) && $stable(l2req_mask_o))
		else $error("L2 request changed while stalled");

	// First cycle out of reset starts quiet
	assert property (@(posedge clk) $fell(reset) |-> !l2req_valid_o && !rollback_o
		&& resume_strands_o == '0)
		else $error("Control output high after reset");

endmodule

// File: testbench/core_mem_tb.sv
// Testbench top: clock, reset, file driven stimulus, L2 ready and response model, DUT instance
`include "core_mem_consts.svh"

module core_mem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STIM_WORDS = 7;	// Columns per line in the data file
	localparam int STIM_LINES = 32;
	localparam int TIMEOUT = 200;	// Cycles allowed for any wait

	logic clk;
	logic reset;
	logic store_valid_i;
	core_mem_pkg::strand_idx_t store_strand_i;
	core_mem_pkg::line_addr_t store_addr_i;
	core_mem_pkg::line_data_t store_data_i;
	core_mem_pkg::byte_mask_t store_mask_i;
	logic rollback_o;
	logic load_valid_i;
	core_mem_pkg::strand_idx_t load_strand_i;
	core_mem_pkg::line_addr_t load_addr_i;
	core_mem_pkg::line_data_t cache_line_i;
	core_mem_pkg::line_data_t load_data_o;
	logic dload_req_valid_i;
	core_mem_pkg::strand_idx_t dload_req_strand_i;
	core_mem_pkg::line_addr_t dload_req_addr_i;
	logic l2req_dload_ready_o;
	logic l2req_valid_o;
	logic l2req_ready_i;
	core_mem_pkg::strand_idx_t l2req_strand_o;
	core_mem_pkg::unit_t l2req_unit_o;
	core_mem_pkg::l2_op_t l2req_op_o;
	core_mem_pkg::line_addr_t l2req_addr_o;
	core_mem_pkg::line_data_t l2req_data_o;
	core_mem_pkg::byte_mask_t l2req_mask_o;
	logic l2rsp_valid_i;
	logic [3:0] l2rsp_core_i;
	core_mem_pkg::unit_t l2rsp_unit_i;
	core_mem_pkg::strand_idx_t l2rsp_strand_i;
	core_mem_pkg::line_addr_t l2rsp_addr_i;
	core_mem_pkg::strand_mask_t resume_strands_o;

	logic [127:0] stim_mem [0:STIM_LINES*STIM_WORDS-1];
	logic timed_out;	// Set by any wait that ran out

	core_mem_top #(.CORE_ID(4'h3)) i_core_mem_top (.*);

	core_mem_checker i_checker
	(
		.clk                 (clk),
		.l2req_valid_o       (l2req_valid_o),
		.l2req_ready_i       (l2req_ready_i),
		.l2req_dload_ready_o (l2req_dload_ready_o),
		.l2req_strand_o      (l2req_strand_o),
		.l2req_unit_o        (l2req_unit_o),
		.l2req_op_o          (l2req_op_o),
		.l2req_addr_o        (l2req_addr_o),
		.l2req_data_o        (l2req_data_o),
		.l2req_mask_o        (l2req_mask_o),
		.rollback_o          (rollback_o),
		.load_data_o         (load_data_o),
		.resume_strands_o    (resume_strands_o)
	);

	bind core_mem_top core_mem_sva i_core_mem_sva
	(
		.clk              (clk),
		.reset            (reset),
		.l2req_valid_o    (l2req_valid_o),
		.l2req_ready_i    (l2req_ready_i),
		.l2req_strand_o   (l2req_strand_o),
		.l2req_unit_o     (l2req_unit_o),
		.l2req_op_o       (l2req_op_o),
		.l2req_addr_o     (l2req_addr_o),
		.l2req_data_o     (l2req_data_o),
		.l2req_mask_o     (l2req_mask_o),
		.rollback_o       (rollback_o),
		.resume_strands_o (resume_strands_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;	// 10 ns period
	end

	// Waits until the checker has seen every expected L2 transfer
	task automatic drain_requests(input string name);
		int waited;
		logic take;
		begin
			waited = 0;
			while (i_checker.pending_requests() > 0 && waited < TIMEOUT)
			begin
				@(negedge clk);
				take = dload_req_valid_i && l2req_dload_ready_o;	// Taken at next edge
				@(posedge clk);
				#1;
				if (take)
					dload_req_valid_i = 1'b0;
				waited++;
			end
			if (waited >= TIMEOUT)
			begin
				$display("Timeout in %s: expected L2 requests never appeared", name);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic send_store(input string name, input logic [127:0] strand, addr, data, mask,
		input logic [127:0] exp_rb);
		begin
			store_valid_i = 1'b1;
			store_strand_i = strand[1:0];
			store_addr_i = addr[27:0];
			store_data_i = data;
			store_mask_i = mask[15:0];
			@(posedge clk);
			#1;
			store_valid_i = 1'b0;
			i_checker.match_rollback(name, exp_rb[0]);	// Registered at capture edge
			if (exp_rb[0])
			begin
				repeat (4) @(posedge clk);	// Checker flags any stray request
				#1;
			end
			else
			begin
				i_checker.expect_request(name, strand[1:0], `UNIT_STBUF, `OP_STORE,
					addr[27:0], data, mask[15:0]);
				if (l2req_ready_i)
					drain_requests(name);
				else
				begin
					@(posedge clk);	// Request goes up one cycle after capture
					#1;
				end
			end
		end
	endtask

	task automatic issue_load(input string name, input logic [127:0] strand, addr, line, exp);
		begin
			load_valid_i = 1'b1;
			load_strand_i = strand[1:0];
			load_addr_i = addr[27:0];
			cache_line_i = line;
			@(posedge clk);
			#1;
			load_valid_i = 1'b0;
			i_checker.compare_load_data(name, exp);
		end
	endtask

	task automatic raise_dload(input string name, input logic [127:0] strand, addr);
		begin
			dload_req_valid_i = 1'b1;	// Dropped by drain after transfer
			dload_req_strand_i = strand[1:0];
			dload_req_addr_i = addr[27:0];
			i_checker.expect_request(name, strand[1:0], `UNIT_DLOAD, `OP_LOAD, addr[27:0],
				'0, '0);
			if (l2req_ready_i)
				drain_requests(name);
			else
			begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic return_response(input string name, input logic [127:0] strand, addr, core,
		unit, input logic [127:0] exp);
		begin
			l2rsp_valid_i = 1'b1;
			l2rsp_strand_i = strand[1:0];
			l2rsp_addr_i = addr[27:0];
			l2rsp_core_i = core[3:0];
			l2rsp_unit_i = unit[1:0];
			@(posedge clk);
			#1;
			l2rsp_valid_i = 1'b0;
			i_checker.verify_resume(name, exp[3:0]);
		end
	endtask

	initial
	begin
		int idx;
		logic [127:0] op;
		string name;
		reset = 1'b1;
		timed_out = 1'b0;
		store_valid_i = 1'b0;
		store_strand_i = '0;
		store_addr_i = '0;
		store_data_i = '0;
		store_mask_i = '0;
		load_valid_i = 1'b0;
		load_strand_i = '0;
		load_addr_i = '0;
		cache_line_i = '0;
		dload_req_valid_i = 1'b0;
		dload_req_strand_i = '0;
		dload_req_addr_i = '0;
		l2req_ready_i = 1'b1;	// L2 model takes requests unless told otherwise
		l2rsp_valid_i = 1'b0;
		l2rsp_core_i = '0;
		l2rsp_unit_i = '0;
		l2rsp_strand_i = '0;
		l2rsp_addr_i = '0;
		$readmemh("testbench/core_mem_stim.txt", stim_mem);
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		idx = 0;
		op = stim_mem[1];
		while (op != 0 && idx < STIM_LINES && !timed_out)
		begin
			name = $sformatf("test_%02h", stim_mem[idx*STIM_WORDS][7:0]);
			case (op)
				1: send_store(name, stim_mem[idx*STIM_WORDS+2], stim_mem[idx*STIM_WORDS+3],
					stim_mem[idx*STIM_WORDS+4], stim_mem[idx*STIM_WORDS+5],
					stim_mem[idx*STIM_WORDS+6]);
				2: issue_load(name, stim_mem[idx*STIM_WORDS+2], stim_mem[idx*STIM_WORDS+3],
					stim_mem[idx*STIM_WORDS+4], stim_mem[idx*STIM_WORDS+6]);
				3: raise_dload(name, stim_mem[idx*STIM_WORDS+2], stim_mem[idx*STIM_WORDS+3]);
				4: return_response(name, stim_mem[idx*STIM_WORDS+2],
					stim_mem[idx*STIM_WORDS+3], stim_mem[idx*STIM_WORDS+4],
					stim_mem[idx*STIM_WORDS+5], stim_mem[idx*STIM_WORDS+6]);
				default:
				begin
					l2req_ready_i = stim_mem[idx*STIM_WORDS+4][0];	// Ready pattern
					if (l2req_ready_i)
						drain_requests(name);
					else
					begin
						@(posedge clk);
						#1;
					end
				end
			endcase
			idx++;
			if (idx < STIM_LINES)
				op = stim_mem[idx*STIM_WORDS+1];
		end
		repeat (4) @(posedge clk);
		i_checker.print_summary();
		if (timed_out || i_checker.failed_checks() != 0 || i_checker.pending_requests() != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hw/core_mem_pkg.sv
hw/l2_if.sv
hw/store_buffer.sv
hw/l2_arbiter.sv
hw/l2_response_router.sv
hw/core_mem_top.sv
testbench/core_mem_sva.sv
testbench/core_mem_checker.sv
testbench/core_mem_tb.sv
